// File: bmc_pkg.sv
package bmc_pkg;

  localparam int CHAN_W       = 5;
  localparam int ADC_W        = 12;
  localparam int NUM_CHANNELS = 32;
  localparam int TIMER_W      = 16;

  // Defaults for the top level parameters
  localparam int DEF_NUM_RAILS      = 5;
  localparam int DEF_STEP_WAIT      = 16;
  localparam int DEF_PWR_OK_TIMEOUT = 200;
  localparam int DEF_FIFO_DEPTH     = 4;

  // One ADC conversion
  typedef struct packed {
    logic [CHAN_W-1:0] channel;
    logic [ADC_W-1:0]  result;
  } sample_t;

  // Soft and hard limits of one channel
  typedef struct packed {
    logic [ADC_W-1:0] soft_lo;
    logic [ADC_W-1:0] soft_hi;
    logic [ADC_W-1:0] hard_lo;
    logic [ADC_W-1:0] hard_hi;
  } threshold_t;

  typedef struct packed {
    logic [CHAN_W-1:0] channel;
    threshold_t        limits;
  } thr_write_t;

  typedef enum logic [0:0] {SOFT, HARD} viol_kind_t;

  // One reported violation
  typedef struct packed {
    logic [CHAN_W-1:0] channel;
    logic [ADC_W-1:0]  result;
    viol_kind_t        kind;
  } event_t;

  typedef enum logic [2:0] {
    ST_OFF, ST_ATX_WAIT, ST_RAIL_UP, ST_ON, ST_RAIL_DOWN, ST_FAULT
  } seq_state_t;

  typedef enum logic [1:0] {
    F_NONE, F_PWR_OK_TIMEOUT, F_HARD_VIOL, F_ATX_LOST
  } fault_t;

  typedef struct packed {
    seq_state_t state;
    logic       power_ok;
    fault_t     fault;
  } power_status_t;

  // Limits that no result can violate
  localparam threshold_t THR_FULL_RANGE = '{soft_lo: '0, soft_hi: '1, hard_lo: '0, hard_hi: '1};

endpackage

// File: credit_fifo.sv
module credit_fifo #(
  parameter int DEPTH      = bmc_pkg::DEF_FIFO_DEPTH,
  parameter type payload_t = logic [7:0],
  parameter bit CREDIT_OUT = 1'b0
) (
  input  logic                         gclk40,
  input  logic                         hard_reset,
  // Write side
  input  payload_t                     wr_data_i,
  input  logic                         wr_valid_i,
  output logic                         wr_credit_o,
  output logic [$clog2(DEPTH + 1)-1:0] free_o,
  // Read side
  input  logic                         rd_pop_i,
  input  logic                         rd_credit_i,
  output payload_t                     rd_data_o,
  output logic                         rd_valid_o
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  payload_t         mem_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic [CNT_W-1:0] credits_q;
  logic             pop;

  // In credit mode the head entry leaves on its own while the consumer holds credits
  assign rd_valid_o = (count_q != '0) && (!CREDIT_OUT || (credits_q != '0));
  assign pop        = rd_valid_o && (CREDIT_OUT || rd_pop_i);
  assign rd_data_o  = mem_q[rd_ptr_q];
  assign free_o     = CNT_W'(DEPTH) - count_q;

  always_ff @(posedge gclk40) begin
    if (wr_valid_i) begin
      mem_q[wr_ptr_q] <= wr_data_i;
    end
  end

  always_ff @(posedge gclk40) begin
    if (!hard_reset) begin
      wr_ptr_q    <= '0;
      rd_ptr_q    <= '0;
      count_q     <= '0;
      credits_q   <= CNT_W'(DEPTH);
      wr_credit_o <= 1'b0;
    end else begin
      if (wr_valid_i) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      count_q <= count_q + CNT_W'(wr_valid_i) - CNT_W'(pop);
      if (CREDIT_OUT) begin
        credits_q <= credits_q + CNT_W'(rd_credit_i) - CNT_W'(pop);
      end
      // Each entry that leaves hands one credit back to the writer
      wr_credit_o <= pop;
    end
  end

  a_no_write_when_full: assert property (
    @(posedge gclk40) disable iff (!hard_reset)
    wr_valid_i |-> (count_q != CNT_W'(DEPTH))
  );

  // The consumer never returns more credits than it was given
  a_credit_bound: assert property (
    @(posedge gclk40) disable iff (!hard_reset)
    credits_q <= CNT_W'(DEPTH)
  );

endmodule

// File: level_checker.sv
module level_checker #(
  parameter int FIFO_DEPTH = bmc_pkg::DEF_FIFO_DEPTH
) (
  input  logic                              gclk40,
  input  logic                              hard_reset,
  // Samples from the sample FIFO
  input  bmc_pkg::sample_t                  sample_i,
  input  logic                              sample_valid_i,
  output logic                              sample_pop_o,
  // Events towards the event FIFO
  input  logic [$clog2(FIFO_DEPTH + 1)-1:0] event_free_i,
  output bmc_pkg::event_t                   event_o,
  output logic                              event_push_o,
  // Threshold updates
  input  bmc_pkg::thr_write_t               thr_wr_i,
  input  logic                              thr_wr_valid_i,
  // Control
  input  logic                              check_en_i,
  output logic                              hard_viol_o
);

  bmc_pkg::threshold_t thr_table_q [bmc_pkg::NUM_CHANNELS];

  logic                s1_valid_q;
  bmc_pkg::sample_t    s1_sample_q;
  bmc_pkg::threshold_t s1_limits;
  logic                is_hard;
  logic                is_soft;
  logic [1:0]          in_flight;

  // Pop only when the event FIFO has room for every result still in the pipeline plus this one
  assign in_flight    = {1'b0, s1_valid_q} + {1'b0, event_push_o};
  assign sample_pop_o = sample_valid_i && (event_free_i > in_flight);

  always_ff @(posedge gclk40) begin
    if (!hard_reset) begin
      for (int i = 0; i < bmc_pkg::NUM_CHANNELS; i++) begin
        thr_table_q[i] <= bmc_pkg::THR_FULL_RANGE;
      end
    end else if (thr_wr_valid_i) begin
      thr_table_q[thr_wr_i.channel] <= thr_wr_i.limits;
    end
  end

  // Stage 1 holds the sample while its limits are looked up
  always_ff @(posedge gclk40) begin
    if (!hard_reset) begin
      s1_valid_q <= 1'b0;
    end else begin
      s1_valid_q <= sample_pop_o;
    end
  end

  always_ff @(posedge gclk40) begin
    if (sample_pop_o) begin
      s1_sample_q <= sample_i;
    end
  end

  assign s1_limits = thr_table_q[s1_sample_q.channel];

  // Hard limits take priority over soft ones
  assign is_hard = (s1_sample_q.result < s1_limits.hard_lo) ||
                   (s1_sample_q.result > s1_limits.hard_hi);
  assign is_soft = (s1_sample_q.result < s1_limits.soft_lo) ||
                   (s1_sample_q.result > s1_limits.soft_hi);

  // Stage 2 is the event register that feeds the event FIFO
  always_ff @(posedge gclk40) begin
    if (!hard_reset) begin
      event_push_o <= 1'b0;
    end else begin
      event_push_o <= s1_valid_q && check_en_i && (is_hard || is_soft);
    end
  end

  always_ff @(posedge gclk40) begin
    if (s1_valid_q) begin
      event_o.channel <= s1_sample_q.channel;
      event_o.result  <= s1_sample_q.result;
      event_o.kind    <= is_hard ? bmc_pkg::HARD : bmc_pkg::SOFT;
    end
  end

  assign hard_viol_o = event_push_o && (event_o.kind == bmc_pkg::HARD);

  // The pop rule must keep the event FIFO from overflowing
  a_push_has_room: assert property (
    @(posedge gclk40) disable iff (!hard_reset)
    event_push_o |-> (event_free_i != '0)
  );

endmodule

// File: power_monitor_top.sv
module power_monitor_top #(
  parameter int NUM_RAILS      = bmc_pkg::DEF_NUM_RAILS,
  parameter int STEP_WAIT      = bmc_pkg::DEF_STEP_WAIT,
  parameter int PWR_OK_TIMEOUT = bmc_pkg::DEF_PWR_OK_TIMEOUT,
  parameter int FIFO_DEPTH     = bmc_pkg::DEF_FIFO_DEPTH
) (
  input  logic                   gclk40,
  input  logic                   hard_reset,
  input  logic                   power_button_i,
  input  logic                   atx_pwr_ok_i,
  input  bmc_pkg::sample_t       sample_i,
  input  logic                   sample_valid_i,
  input  bmc_pkg::thr_write_t    thr_wr_i,
  input  logic                   thr_wr_valid_i,
  input  logic                   event_credit_i,
  output logic                   atx_ps_on_n_o,
  output logic [NUM_RAILS-1:0]   rail_en_o,
  output bmc_pkg::power_status_t status_o,
  output logic                   sample_credit_o,
  output bmc_pkg::event_t        event_o,
  output logic                   event_valid_o
);

  localparam int FREE_W = $clog2(FIFO_DEPTH + 1);

  bmc_pkg::sample_t  fifo_sample;
  logic              fifo_sample_valid;
  logic              sample_pop;
  bmc_pkg::event_t   chk_event;
  logic              event_push;
  logic [FREE_W-1:0] event_free;
  logic              check_en;
  logic              hard_viol;

  // Sample path with credits returned to the ADC source
  credit_fifo #(
    .DEPTH      (FIFO_DEPTH),
    .payload_t  (bmc_pkg::sample_t),
    .CREDIT_OUT (1'b0)
  ) u_sample_fifo (
    .gclk40      (gclk40),
    .hard_reset  (hard_reset),
    .wr_data_i   (sample_i),
    .wr_valid_i  (sample_valid_i),
    .wr_credit_o (sample_credit_o),
    .free_o      (),
    .rd_pop_i    (sample_pop),
    .rd_credit_i (1'b0),
    .rd_data_o   (fifo_sample),
    .rd_valid_o  (fifo_sample_valid)
  );

  level_checker #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_level_checker (
    .gclk40         (gclk40),
    .hard_reset     (hard_reset),
    .sample_i       (fifo_sample),
    .sample_valid_i (fifo_sample_valid),
    .sample_pop_o   (sample_pop),
    .event_free_i   (event_free),
    .event_o        (chk_event),
    .event_push_o   (event_push),
    .thr_wr_i       (thr_wr_i),
    .thr_wr_valid_i (thr_wr_valid_i),
    .check_en_i     (check_en),
    .hard_viol_o    (hard_viol)
  );

  // Event path drained by the consumer's credits
  credit_fifo #(
    .DEPTH      (FIFO_DEPTH),
    .payload_t  (bmc_pkg::event_t),
    .CREDIT_OUT (1'b1)
  ) u_event_fifo (
    .gclk40      (gclk40),
    .hard_reset  (hard_reset),
    .wr_data_i   (chk_event),
    .wr_valid_i  (event_push),
    .wr_credit_o (),
    .free_o      (event_free),
    .rd_pop_i    (1'b0),
    .rd_credit_i (event_credit_i),
    .rd_data_o   (event_o),
    .rd_valid_o  (event_valid_o)
  );

  power_sequencer #(
    .NUM_RAILS      (NUM_RAILS),
    .STEP_WAIT      (STEP_WAIT),
    .PWR_OK_TIMEOUT (PWR_OK_TIMEOUT)
  ) u_power_sequencer (
    .gclk40         (gclk40),
    .hard_reset     (hard_reset),
    .power_button_i (power_button_i),
    .atx_pwr_ok_i   (atx_pwr_ok_i),
    .hard_viol_i    (hard_viol),
    .atx_ps_on_n_o  (atx_ps_on_n_o),
    .rail_en_o      (rail_en_o),
    .check_en_o     (check_en),
    .status_o       (status_o)
  );

endmodule

// File: power_sequencer.sv
module power_sequencer #(
  parameter int NUM_RAILS      = bmc_pkg::DEF_NUM_RAILS,
  parameter int STEP_WAIT      = bmc_pkg::DEF_STEP_WAIT,
  parameter int PWR_OK_TIMEOUT = bmc_pkg::DEF_PWR_OK_TIMEOUT
) (
  input  logic                   gclk40,
  input  logic                   hard_reset,
  input  logic                   power_button_i,
  input  logic                   atx_pwr_ok_i,
  input  logic                   hard_viol_i,
  output logic                   atx_ps_on_n_o,
  output logic [NUM_RAILS-1:0]   rail_en_o,
  output logic                   check_en_o,
  output bmc_pkg::power_status_t status_o
);

  localparam int TW    = bmc_pkg::TIMER_W;
  localparam int IDX_W = $clog2(NUM_RAILS + 1);
  // The FSM acts on the edge after expiry, so each delay is loaded one short
  localparam logic [TW-1:0] STEP_LOAD   = TW'(STEP_WAIT - 1);
  localparam logic [TW-1:0] PWR_OK_LOAD = TW'(PWR_OK_TIMEOUT - 1);

  bmc_pkg::seq_state_t state_q;
  bmc_pkg::fault_t     fault_q;
  logic [IDX_W-1:0]    rail_idx_q;
  logic                timer_load;
  logic [TW-1:0]       timer_value;
  logic                timer_expired;

  seq_timer u_seq_timer (
    .gclk40       (gclk40),
    .hard_reset   (hard_reset),
    .load_i       (timer_load),
    .load_value_i (timer_value),
    .expired_o    (timer_expired)
  );

  always_comb begin
    timer_load  = 1'b0;
    timer_value = STEP_LOAD;
    case (state_q)
      bmc_pkg::ST_OFF, bmc_pkg::ST_FAULT: begin
        timer_load  = power_button_i;
        timer_value = PWR_OK_LOAD;
      end
      bmc_pkg::ST_ATX_WAIT:  timer_load = atx_pwr_ok_i;
      bmc_pkg::ST_RAIL_UP:   timer_load = timer_expired || !atx_pwr_ok_i;
      bmc_pkg::ST_ON:        timer_load = power_button_i || hard_viol_i || !atx_pwr_ok_i;
      bmc_pkg::ST_RAIL_DOWN: timer_load = timer_expired;
      default:               timer_load = 1'b0;
    endcase
  end

  always_ff @(posedge gclk40) begin
    if (!hard_reset) begin
      state_q       <= bmc_pkg::ST_OFF;
      fault_q       <= bmc_pkg::F_NONE;
      rail_idx_q    <= '0;
      rail_en_o     <= '0;
      atx_ps_on_n_o <= 1'b1;
    end else begin
      case (state_q)
        bmc_pkg::ST_OFF, bmc_pkg::ST_FAULT: begin
          if (power_button_i) begin
            atx_ps_on_n_o <= 1'b0;
            fault_q       <= bmc_pkg::F_NONE;
            state_q       <= bmc_pkg::ST_ATX_WAIT;
          end
        end
        bmc_pkg::ST_ATX_WAIT: begin
          if (atx_pwr_ok_i) begin
            rail_idx_q <= '0;
            state_q    <= bmc_pkg::ST_RAIL_UP;
          end else if (timer_expired) begin
            atx_ps_on_n_o <= 1'b1;
            fault_q       <= bmc_pkg::F_PWR_OK_TIMEOUT;
            state_q       <= bmc_pkg::ST_FAULT;
          end
        end
        bmc_pkg::ST_RAIL_UP: begin
          if (!atx_pwr_ok_i) begin
            fault_q <= bmc_pkg::F_ATX_LOST;
            state_q <= bmc_pkg::ST_RAIL_DOWN;
          end else if (timer_expired) begin
            // One extra step after the last rail before declaring power good
            if (rail_idx_q == IDX_W'(NUM_RAILS)) begin
              state_q <= bmc_pkg::ST_ON;
            end else begin
              rail_en_o[rail_idx_q] <= 1'b1;
              rail_idx_q            <= rail_idx_q + 1'b1;
            end
          end
        end
        bmc_pkg::ST_ON: begin
          if (hard_viol_i) begin
            fault_q <= bmc_pkg::F_HARD_VIOL;
            state_q <= bmc_pkg::ST_RAIL_DOWN;
          end else if (!atx_pwr_ok_i) begin
            fault_q <= bmc_pkg::F_ATX_LOST;
            state_q <= bmc_pkg::ST_RAIL_DOWN;
          end else if (power_button_i) begin
            state_q <= bmc_pkg::ST_RAIL_DOWN;
          end
        end
        bmc_pkg::ST_RAIL_DOWN: begin
          if (timer_expired) begin
            if (rail_idx_q == '0) begin
              atx_ps_on_n_o <= 1'b1;
              state_q <= (fault_q == bmc_pkg::F_NONE) ? bmc_pkg::ST_OFF : bmc_pkg::ST_FAULT;
            end else begin
              rail_en_o[rail_idx_q - 1'b1] <= 1'b0;
              rail_idx_q                   <= rail_idx_q - 1'b1;
            end
          end
        end
        default: state_q <= bmc_pkg::ST_OFF;
      endcase
    end
  end

  assign check_en_o        = (state_q == bmc_pkg::ST_ON);
  assign status_o.state    = state_q;
  assign status_o.power_ok = (state_q == bmc_pkg::ST_ON);
  assign status_o.fault    = fault_q;

  // Rails are switched strictly in order, so the enables form a run from bit 0
  a_rails_contiguous: assert property (
    @(posedge gclk40) disable iff (!hard_reset)
    ((({1'b0, rail_en_o} + 1'b1) & {1'b0, rail_en_o}) == '0)
  );

  a_on_means_all_up: assert property (
    @(posedge gclk40) disable iff (!hard_reset)
    (state_q == bmc_pkg::ST_ON) |-> ((rail_en_o == '1) && !atx_ps_on_n_o)
  );

endmodule

// File: seq_timer.sv
module seq_timer (
  input  logic                        gclk40,
  input  logic                        hard_reset,
  input  logic                        load_i,
  input  logic [bmc_pkg::TIMER_W-1:0] load_value_i,
  output logic                        expired_o
);

  logic [bmc_pkg::TIMER_W-1:0] count_q;

  // Counts down to zero and stays there until the next load
  always_ff @(posedge gclk40) begin
    if (!hard_reset) begin
      count_q <= '0;
    end else if (load_i) begin
      count_q <= load_value_i;
    end else if (count_q != '0) begin
      count_q <= count_q - 1'b1;
    end
  end

  assign expired_o = (count_q == '0);

endmodule

// File: sources.f
bmc_pkg.sv
credit_fifo.sv
level_checker.sv
seq_timer.sv
power_sequencer.sv
power_monitor_top.sv
tb_power_monitor.sv

// File: tb_power_monitor.sv
module tb_power_monitor;

  localparam int NUM_RAILS      = bmc_pkg::DEF_NUM_RAILS;
  localparam int STEP_WAIT      = bmc_pkg::DEF_STEP_WAIT;
  localparam int PWR_OK_TIMEOUT = bmc_pkg::DEF_PWR_OK_TIMEOUT;
  localparam int FIFO_DEPTH     = bmc_pkg::DEF_FIFO_DEPTH;
  localparam int NUM_OFF        = 20;
  localparam int NUM_RANDOM     = 300;
  localparam int NUM_BACKPRESS  = 60;
  localparam int HOLD_CYCLES    = 200;
  localparam int SUPPLY_DELAY   = 3;
  // One full power cycle up and down plus the supply timeout
  localparam int SEQ_CYCLES      = PWR_OK_TIMEOUT + 2 * (NUM_RAILS + 2) * STEP_WAIT;
  localparam int WATCHDOG_CYCLES = 4 * SEQ_CYCLES + HOLD_CYCLES + 500 +
                                   8 * (NUM_OFF + NUM_RANDOM + NUM_BACKPRESS);

  logic                   gclk40;
  logic                   hard_reset;
  logic                   power_button_i;
  logic                   atx_pwr_ok_i;
  bmc_pkg::sample_t       sample_i;
  logic                   sample_valid_i;
  bmc_pkg::thr_write_t    thr_wr_i;
  logic                   thr_wr_valid_i;
  logic                   event_credit_i;
  logic                   atx_ps_on_n_o;
  logic [NUM_RAILS-1:0]   rail_en_o;
  bmc_pkg::power_status_t status_o;
  logic                   sample_credit_o;
  bmc_pkg::event_t        event_o;
  logic                   event_valid_o;

  integer              seed = 32'hdb06_88a9;
  int                  cycle = 0;
  int                  error_count = 0;
  int                  sent_total = 0;
  int                  returned_total = 0;
  int                  ev_seen = 0;
  int                  ev_returned = 0;
  int                  supply_count = 0;
  bit                  expect_on = 1'b0;
  bit                  hold_credits = 1'b0;
  bit                  supply_on = 1'b1;
  bmc_pkg::threshold_t thr_model [bmc_pkg::NUM_CHANNELS];
  bmc_pkg::event_t     exp_q [$];
  int                  rise_cyc [NUM_RAILS];
  int                  fall_cyc [NUM_RAILS];
  int                  pwr_ok_cyc;
  int                  ps_off_cyc;

  power_monitor_top DUT (
    .gclk40          (gclk40),
    .hard_reset      (hard_reset),
    .power_button_i  (power_button_i),
    .atx_pwr_ok_i    (atx_pwr_ok_i),
    .sample_i        (sample_i),
    .sample_valid_i  (sample_valid_i),
    .thr_wr_i        (thr_wr_i),
    .thr_wr_valid_i  (thr_wr_valid_i),
    .event_credit_i  (event_credit_i),
    .atx_ps_on_n_o   (atx_ps_on_n_o),
    .rail_en_o       (rail_en_o),
    .status_o        (status_o),
    .sample_credit_o (sample_credit_o),
    .event_o         (event_o),
    .event_valid_o   (event_valid_o)
  );

  initial begin
    gclk40 = 1'b0;
    forever #10 gclk40 = ~gclk40;
  end

  always @(posedge gclk40) begin
    cycle <= cycle + 1;
  end

  task automatic abort_run();
    error_count++;
    $display("SIMULATION FAILED");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp) else begin
      $display("FAIL %s: got %h expected %h", name, got, exp);
      abort_run();
    end
  endtask

  // Expected event of one sample with hard limits ahead of soft ones
  function automatic bit ref_event(input bmc_pkg::sample_t s, input bmc_pkg::threshold_t t,
                                   output bmc_pkg::event_t ev);
    ev.channel = s.channel;
    ev.result  = s.result;
    ev.kind    = bmc_pkg::SOFT;
    if (s.result < t.hard_lo || s.result > t.hard_hi) begin
      ev.kind = bmc_pkg::HARD;
      return 1'b1;
    end
    return (s.result < t.soft_lo || s.result > t.soft_hi);
  endfunction

  function automatic int sample_credits();
    return FIFO_DEPTH - (sent_total - returned_total);
  endfunction

  function automatic bmc_pkg::sample_t random_sample();
    bmc_pkg::sample_t s;
    s.channel = 5'($random(seed));
    s.result  = 12'($random(seed));
    return s;
  endfunction

  // The supply raises pwr_ok a few cycles after ps_on_n falls
  always @(posedge gclk40) begin
    if (!hard_reset || atx_ps_on_n_o !== 1'b0 || !supply_on) begin
      atx_pwr_ok_i <= 1'b0;
      supply_count <= 0;
    end else if (supply_count == SUPPLY_DELAY) begin
      atx_pwr_ok_i <= 1'b1;
    end else begin
      supply_count <= supply_count + 1;
    end
  end

  always @(negedge gclk40) begin
    if (sample_credit_o === 1'b1) begin
      returned_total++;
    end
    assert (sample_credits() >= 0 && sample_credits() <= FIFO_DEPTH) else begin
      $display("Sample credit count left the range 0 to %0d", FIFO_DEPTH);
      abort_run();
    end
  end

  // Comparer for the event output
  always @(negedge gclk40) begin
    if (event_valid_o === 1'b1) begin
      ev_seen++;
      assert (exp_q.size() > 0) else begin
        $display("An event arrived when none was expected");
        abort_run();
      end
      assert (event_o === exp_q[0]) else begin
        $display("FAIL event_o: got %h expected %h", event_o, exp_q[0]);
        abort_run();
      end
      exp_q.delete(0);
    end
  end

  // Each received event hands its credit back unless credits are withheld
  always @(posedge gclk40) begin
    if (!hold_credits && ev_returned < ev_seen) begin
      event_credit_i <= 1'b1;
      ev_returned++;
    end else begin
      event_credit_i <= 1'b0;
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge gclk40);
    $display("Timeout: the run did not end within %0d clock cycles", WATCHDOG_CYCLES);
    abort_run();
  end

  task automatic send_sample(input bmc_pkg::sample_t s);
    bmc_pkg::event_t ev;
    @(posedge gclk40);
    while (sample_credits() == 0) begin
      sample_valid_i <= 1'b0;
      @(posedge gclk40);
    end
    sample_i       <= s;
    sample_valid_i <= 1'b1;
    sent_total++;
    if (expect_on && ref_event(s, thr_model[s.channel], ev)) begin
      exp_q.push_back(ev);
    end
  endtask

  task automatic end_samples();
    @(posedge gclk40);
    sample_valid_i <= 1'b0;
  endtask

  task automatic send_random(input int n);
    for (int i = 0; i < n; i++) begin
      send_sample(random_sample());
      // Occasional idle cycle on the sample input
      if (($random(seed) & 7) == 0) begin
        @(posedge gclk40);
        sample_valid_i <= 1'b0;
      end
    end
    end_samples();
  endtask

  task automatic write_threshold(input int ch, input bmc_pkg::threshold_t lim);
    bmc_pkg::thr_write_t w;
    w.channel = 5'(ch);
    w.limits  = lim;
    @(posedge gclk40);
    thr_wr_i       <= w;
    thr_wr_valid_i <= 1'b1;
    thr_model[ch] = lim;
  endtask

  task automatic write_random_thresholds();
    bmc_pkg::threshold_t lim;
    for (int ch = 0; ch < bmc_pkg::NUM_CHANNELS; ch++) begin
      // Hard limits stay at full range so random traffic never trips a shutdown
      lim.hard_lo = '0;
      lim.hard_hi = '1;
      lim.soft_lo = 12'($random(seed)) & 12'h7ff;
      lim.soft_hi = 12'($random(seed)) | 12'h800;
      write_threshold(ch, lim);
    end
    @(posedge gclk40);
    thr_wr_valid_i <= 1'b0;
  endtask

  task automatic press_button();
    @(posedge gclk40);
    power_button_i <= 1'b1;
    @(posedge gclk40);
    power_button_i <= 1'b0;
  endtask

  task automatic wait_drained();
    do @(negedge gclk40); while (exp_q.size() != 0 || sent_total != returned_total);
    repeat (8) @(negedge gclk40);
  endtask

  // Logs the cycle of every rail change until the FSM reaches the target state
  task automatic record_sequence(input bmc_pkg::seq_state_t target);
    logic [NUM_RAILS-1:0] prev;
    prev       = rail_en_o;
    pwr_ok_cyc = -1;
    ps_off_cyc = -1;
    do begin
      @(negedge gclk40);
      if (atx_pwr_ok_i && pwr_ok_cyc < 0) pwr_ok_cyc = cycle;
      if (atx_ps_on_n_o && ps_off_cyc < 0) ps_off_cyc = cycle;
      if (rail_en_o != prev) begin
        assert (rail_en_o == {prev[NUM_RAILS-2:0], 1'b1} || rail_en_o == (prev >> 1)) else begin
          $display("FAIL rail_en_o: got %h after %h, not a single step in order", rail_en_o, prev);
          abort_run();
        end
        for (int i = 0; i < NUM_RAILS; i++) begin
          if (rail_en_o[i] && !prev[i]) rise_cyc[i] = cycle;
          if (!rail_en_o[i] && prev[i]) fall_cyc[i] = cycle;
        end
        prev = rail_en_o;
      end
    end while (status_o.state != target);
  endtask

  initial begin
    bmc_pkg::threshold_t lim;
    bmc_pkg::sample_t    s;
    int                  start;
    hard_reset     = 1'b0;
    power_button_i = 1'b0;
    atx_pwr_ok_i   = 1'b0;
    sample_i       = '0;
    sample_valid_i = 1'b0;
    thr_wr_i       = '0;
    thr_wr_valid_i = 1'b0;
    event_credit_i = 1'b0;
    for (int ch = 0; ch < bmc_pkg::NUM_CHANNELS; ch++) begin
      thr_model[ch] = '{soft_lo: '0, soft_hi: '1, hard_lo: '0, hard_hi: '1};
    end
    repeat (5) @(posedge gclk40);
    hard_reset <= 1'b1;

    @(negedge gclk40);
    check_value("atx_ps_on_n_o", atx_ps_on_n_o, 1);
    check_value("rail_en_o", rail_en_o, 0);
    check_value("status_o.power_ok", status_o.power_ok, 0);
    check_value("status_o.state", status_o.state, bmc_pkg::ST_OFF);
    repeat (10) begin
      @(negedge gclk40);
      check_value("event_valid_o", event_valid_o, 0);
      check_value("sample_credit_o", sample_credit_o, 0);
    end

    // Violating samples are ignored while power is off
    write_random_thresholds();
    expect_on = 1'b0;
    send_random(NUM_OFF);
    wait_drained();

    press_button();
    @(negedge gclk40);
    check_value("atx_ps_on_n_o", atx_ps_on_n_o, 0);
    check_value("status_o.state", status_o.state, bmc_pkg::ST_ATX_WAIT);
    record_sequence(bmc_pkg::ST_ON);
    // The FSM samples pwr_ok on the edge after the supply drives it
    check_value("rail_en_o[0] rise cycle", rise_cyc[0], pwr_ok_cyc + 1 + STEP_WAIT);
    for (int i = 1; i < NUM_RAILS; i++) begin
      check_value($sformatf("rail_en_o[%0d] rise cycle", i), rise_cyc[i],
                  rise_cyc[i-1] + STEP_WAIT);
    end
    check_value("status_o.state ST_ON cycle", cycle, rise_cyc[NUM_RAILS-1] + STEP_WAIT);
    check_value("status_o.power_ok", status_o.power_ok, 1);

    write_random_thresholds();
    expect_on = 1'b1;
    send_random(NUM_RANDOM);
    wait_drained();

    // Withheld event credits must stall the whole path back to the source
    hold_credits = 1'b1;
    fork
      send_random(NUM_BACKPRESS);
      begin
        repeat (HOLD_CYCLES) @(negedge gclk40);
        assert (sample_credits() == 0) else begin
          $display("The sample source never stalled while event credits were withheld");
          abort_run();
        end
        hold_credits = 1'b0;
      end
    join
    wait_drained();

    lim = '{soft_lo: 12'h200, soft_hi: 12'hc00, hard_lo: 12'h100, hard_hi: 12'he00};
    write_threshold(3, lim);
    @(posedge gclk40);
    thr_wr_valid_i <= 1'b0;
    s.channel = 5'd3;
    s.result  = 12'hf00;
    send_sample(s);
    end_samples();
    record_sequence(bmc_pkg::ST_FAULT);
    expect_on = 1'b0;
    for (int i = NUM_RAILS - 2; i >= 0; i--) begin
      check_value($sformatf("rail_en_o[%0d] fall cycle", i), fall_cyc[i],
                  fall_cyc[i+1] + STEP_WAIT);
    end
    assert (ps_off_cyc > fall_cyc[0]) else begin
      $display("ATX supply was switched off before all rails were down");
      abort_run();
    end
    check_value("rail_en_o", rail_en_o, 0);
    check_value("atx_ps_on_n_o", atx_ps_on_n_o, 1);
    check_value("status_o.fault", status_o.fault, bmc_pkg::F_HARD_VIOL);
    check_value("status_o.power_ok", status_o.power_ok, 0);
    wait_drained();

    // The supply never answers this time
    supply_on = 1'b0;
    press_button();
    @(negedge gclk40);
    start = cycle;
    check_value("atx_ps_on_n_o", atx_ps_on_n_o, 0);
    check_value("status_o.state", status_o.state, bmc_pkg::ST_ATX_WAIT);
    do begin
      @(negedge gclk40);
      check_value("rail_en_o", rail_en_o, 0);
    end while (status_o.state != bmc_pkg::ST_FAULT);
    check_value("status_o.state ST_FAULT cycle", cycle, start + PWR_OK_TIMEOUT);
    check_value("status_o.fault", status_o.fault, bmc_pkg::F_PWR_OK_TIMEOUT);
    @(negedge gclk40);
    check_value("atx_ps_on_n_o", atx_ps_on_n_o, 1);

    if (error_count == 0) begin
      $display("SIMULATION PASSED");
      $finish;
    end else begin
      abort_run();
    end
  end

endmodule
